//--- riscvPkg.sv
package riscvPkg;

    // Datapath and register index widths
    localparam int dataWidth = 32;
    localparam int regAddrWidth = 5;

    // Writeback result source
    // Order follows the result mux inputs
    typedef enum logic [2:0] {
        resultAlu      = 3'd0,
        resultPcTarget = 3'd1,
        resultPcPlus4  = 3'd2,
        resultImm      = 3'd3,
        resultMemData  = 3'd4
    } resultSrcT;

    // Load/store width, encoded as funct3
    typedef enum logic [2:0] {
        widthByte  = 3'b000,
        widthHalf  = 3'b001,
        widthWord  = 3'b010,
        widthByteU = 3'b100,
        widthHalfU = 3'b101
    } memWidthT;

    // Execute to memory bundle
    typedef struct packed {
        // Also the data memory byte address
        logic [dataWidth-1:0]    aluResult;
        // Store data, unshifted
        logic [dataWidth-1:0]    writeData;
        logic [dataWidth-1:0]    pcTarget;
        logic [dataWidth-1:0]    pcPlus4;
        logic [dataWidth-1:0]    immExt;
        logic [regAddrWidth-1:0] rd;
        resultSrcT               resultSrc;
        memWidthT                memWidth;
        logic                    memWrite;
        logic                    regWrite;
    } exMemT;

    // Memory to writeback bundle
    // Field order matches the 169-bit writeback register
    typedef struct packed {
        logic [dataWidth-1:0]    aluResult;
        // Load data after byte/half extraction and extension
        logic [dataWidth-1:0]    reducedData;
        logic [dataWidth-1:0]    pcTarget;
        logic [dataWidth-1:0]    pcPlus4;
        logic [dataWidth-1:0]    immExt;
        logic [regAddrWidth-1:0] rd;
        resultSrcT               resultSrc;
        logic                    regWrite;
    } memWbT;

endpackage

//--- memoryStage.sv
`timescale 1ns/1ps

module memoryStage #(
    parameter int dmemWords = 256
) (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              stallM,
    input  riscvPkg::exMemT                   exIn,
    output riscvPkg::memWbT                   memWb,
    output logic [riscvPkg::dataWidth-1:0]    aluResultM,
    output logic [riscvPkg::regAddrWidth-1:0] rdM,
    output logic                              regWriteM
);

    // Word index bits taken from the byte address
    localparam int idxWidth = $clog2(dmemWords);

    // Execute to memory register
    riscvPkg::exMemT exM;

    // Word-wide data memory, no reset
    logic [riscvPkg::dataWidth-1:0] dmem [dmemWords];

    logic [idxWidth-1:0]            wordIdx;
    logic [1:0]                     byteOff;
    logic [3:0]                     byteEn;
    logic [riscvPkg::dataWidth-1:0] storeData;
    logic [riscvPkg::dataWidth-1:0] readWord;
    logic [riscvPkg::dataWidth-1:0] laneData;
    logic [riscvPkg::dataWidth-1:0] reducedData;
    logic                           isLoad;

    // Pipeline register, held while stalled
    always_ff @(posedge clk) begin
        if (!rstN) begin
            exM <= '0;
        end else if (!stallM) begin
            exM <= exIn;
        end
    end

    assign wordIdx = exM.aluResult[idxWidth+1:2];
    assign byteOff = exM.aluResult[1:0];
    assign isLoad  = (exM.resultSrc == riscvPkg::resultMemData);

    // Lane enables and replicated store data
    always_comb begin
        byteEn    = 4'b0000;
        storeData = exM.writeData;
        case (exM.memWidth)
            riscvPkg::widthByte, riscvPkg::widthByteU: begin
                byteEn    = 4'b0001 << byteOff;
                storeData = {4{exM.writeData[7:0]}};
            end
            riscvPkg::widthHalf, riscvPkg::widthHalfU: begin
                // Half-word lanes, address bit 0 ignored
                byteEn    = 4'b0011 << {byteOff[1], 1'b0};
                storeData = {2{exM.writeData[15:0]}};
            end
            riscvPkg::widthWord: begin
                byteEn = 4'b1111;
            end
            default: begin
                byteEn = 4'b0000;
            end
        endcase
    end

    // Byte-lane store
    // A held store just rewrites the same bytes
    always_ff @(posedge clk) begin
        if (exM.memWrite) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (byteEn[lane]) begin
                    dmem[wordIdx][8*lane +: 8] <= storeData[8*lane +: 8];
                end
            end
        end
    end

    // Asynchronous read of the addressed word
    assign readWord = dmem[wordIdx];

    // Addressed byte or half moved down to bit 0
    assign laneData = readWord >> {byteOff, 3'b000};

    // Sign or zero extension by width
    always_comb begin
        case (exM.memWidth)
            riscvPkg::widthByte:  reducedData = {{24{laneData[7]}}, laneData[7:0]};
            riscvPkg::widthHalf:  reducedData = {{16{laneData[15]}}, laneData[15:0]};
            riscvPkg::widthByteU: reducedData = {24'b0, laneData[7:0]};
            riscvPkg::widthHalfU: reducedData = {16'b0, laneData[15:0]};
            default:              reducedData = readWord;
        endcase
    end

    // Bundle for writeback
    always_comb begin
        memWb.aluResult   = exM.aluResult;
        memWb.reducedData = reducedData;
        memWb.pcTarget    = exM.pcTarget;
        memWb.pcPlus4     = exM.pcPlus4;
        memWb.immExt      = exM.immExt;
        memWb.rd          = exM.rd;
        memWb.resultSrc   = exM.resultSrc;
        memWb.regWrite    = exM.regWrite;
    end

    // Forwarding taps
    assign aluResultM = exM.aluResult;
    assign rdM        = exM.rd;
    assign regWriteM  = exM.regWrite;

    // No trap logic, misalignment is only flagged here
    aAligned: assert property (@(posedge clk) disable iff (!rstN)
        (exM.memWrite || isLoad) |->
            ((exM.memWidth inside {riscvPkg::widthHalf, riscvPkg::widthHalfU})
                ? !byteOff[0]
                : ((exM.memWidth == riscvPkg::widthWord) ? (byteOff == 2'b00) : 1'b1)))
        else $error("memoryStage: misaligned access at %h", exM.aluResult);

    // Upper address bits must not alias into the memory
    aInRange: assert property (@(posedge clk) disable iff (!rstN)
        (exM.memWrite || isLoad) |-> (exM.aluResult[31:2] < dmemWords))
        else $error("memoryStage: word index out of range at %h", exM.aluResult);

endmodule

//--- writebackStage.sv
`timescale 1ns/1ps

module writebackStage (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              stallW,
    input  riscvPkg::memWbT                   memWb,
    output logic [riscvPkg::dataWidth-1:0]    resultW,
    output logic [riscvPkg::regAddrWidth-1:0] rdW,
    output logic                              regWriteW
);

    // Memory to writeback register
    riscvPkg::memWbT wbReg;

    // Holds while stallW is high
    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbReg <= '0;
        end else if (!stallW) begin
            wbReg <= memWb;
        end
    end

    // Five-way result select
    always_comb begin
        case (wbReg.resultSrc)
            riscvPkg::resultAlu: begin
                resultW = wbReg.aluResult;
            end
            riscvPkg::resultPcTarget: begin
                resultW = wbReg.pcTarget;
            end
            riscvPkg::resultPcPlus4: begin
                resultW = wbReg.pcPlus4;
            end
            riscvPkg::resultImm: begin
                resultW = wbReg.immExt;
            end
            riscvPkg::resultMemData: begin
                resultW = wbReg.reducedData;
            end
            // Unused encodings
            default: begin
                resultW = '0;
            end
        endcase
    end

    // Register file write port
    assign rdW       = wbReg.rd;
    assign regWriteW = wbReg.regWrite;

    // Illegal source would silently write zero to a register
    aSrcDefined: assert property (@(posedge clk) disable iff (!rstN)
        regWriteW |-> (wbReg.resultSrc inside {
            riscvPkg::resultAlu,
            riscvPkg::resultPcTarget,
            riscvPkg::resultPcPlus4,
            riscvPkg::resultImm,
            riscvPkg::resultMemData
        }))
        else $error("writebackStage: undefined resultSrc %0d", wbReg.resultSrc);

endmodule

//--- registerFile.sv
`timescale 1ns/1ps

module registerFile (
    input  logic                              clk,
    input  logic                              rstN,
    input  logic                              writeEn,
    input  logic [riscvPkg::regAddrWidth-1:0] writeAddr,
    input  logic [riscvPkg::dataWidth-1:0]    writeData,
    input  logic [riscvPkg::regAddrWidth-1:0] rs1,
    input  logic [riscvPkg::regAddrWidth-1:0] rs2,
    output logic [riscvPkg::dataWidth-1:0]    rd1,
    output logic [riscvPkg::dataWidth-1:0]    rd2
);

    // One entry per architectural register
    localparam int numRegs = 2 ** riscvPkg::regAddrWidth;

    logic [riscvPkg::dataWidth-1:0] regs [numRegs];

    // Single write port
    // Entry 0 is never written after reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && (writeAddr != '0)) begin
            regs[writeAddr] <= writeData;
        end
    end

    // Combinational reads
    // No bypass of a same-cycle write
    always_comb begin
        if (rs1 == '0) begin
            rd1 = '0;
        end else begin
            rd1 = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rd2 = '0;
        end else begin
            rd2 = regs[rs2];
        end
    end

    // x0 hardwired to zero across all writes
    aZeroReg: assert property (@(posedge clk) disable iff (!rstN)
        regs[0] == '0)
        else $error("registerFile: x0 holds %h", regs[0]);

endmodule

//--- backEnd.sv
`timescale 1ns/1ps

module backEnd #(
    // Data memory depth in words
    parameter int dmemWords = 256
) (
    input  logic                              clk,
    input  logic                              rstN,

    // Execute stage output, driven externally
    input  riscvPkg::exMemT                   exIn,

    // Stall levels per stage
    input  logic                              stallM,
    input  logic                              stallW,

    // Register read ports
    input  logic [riscvPkg::regAddrWidth-1:0] rs1,
    input  logic [riscvPkg::regAddrWidth-1:0] rs2,
    output logic [riscvPkg::dataWidth-1:0]    rd1,
    output logic [riscvPkg::dataWidth-1:0]    rd2,

    // Forwarding taps from the memory register
    output logic [riscvPkg::dataWidth-1:0]    aluResultM,
    output logic [riscvPkg::regAddrWidth-1:0] rdM,
    output logic                              regWriteM,

    // Writeback result
    output logic [riscvPkg::dataWidth-1:0]    resultW,
    output logic [riscvPkg::regAddrWidth-1:0] rdW,
    output logic                              regWriteW
);

    // Memory to writeback bundle
    riscvPkg::memWbT memWb;

    memoryStage #(
        .dmemWords (dmemWords)
    ) i_memoryStage (
        .clk        (clk),
        .rstN       (rstN),
        .stallM     (stallM),
        .exIn       (exIn),
        .memWb      (memWb),
        .aluResultM (aluResultM),
        .rdM        (rdM),
        .regWriteM  (regWriteM)
    );

    writebackStage i_writebackStage (
        .clk       (clk),
        .rstN      (rstN),
        .stallW    (stallW),
        .memWb     (memWb),
        .resultW   (resultW),
        .rdW       (rdW),
        .regWriteW (regWriteW)
    );

    // Writeback drives the write port
    registerFile i_registerFile (
        .clk       (clk),
        .rstN      (rstN),
        .writeEn   (regWriteW),
        .writeAddr (rdW),
        .writeData (resultW),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd1       (rd1),
        .rd2       (rd2)
    );

endmodule

//--- tbBackEnd.sv
`timescale 1ns/1ps

module tbBackEnd;

    localparam int dmemWords = 256;
    localparam int memBytes = dmemWords * 4;
    localparam int maxEntries = 40;
    // Cycles a stall entry is held off before capture
    localparam int stallCycles = 4;
    localparam int waitLimit = 20;

    logic            clk;
    logic            rstN;
    riscvPkg::exMemT exIn;
    logic            stallM;
    logic            stallW;
    logic [4:0]      rs1;
    logic [4:0]      rs2;
    logic [31:0]     rd1;
    logic [31:0]     rd2;
    logic [31:0]     aluResultM;
    logic [4:0]      rdM;
    logic            regWriteM;
    logic [31:0]     resultW;
    logic [4:0]      rdW;
    logic            regWriteW;

    // Stimulus table, expected results filled in at capture
    string           names [maxEntries];
    riscvPkg::exMemT exTab [maxEntries];
    bit              stallTab [maxEntries];
    logic [31:0]     expTab [maxEntries];
    int              numEntries;

    // Byte-wide memory model and register model
    logic [7:0]      modelMem [memBytes];
    logic [31:0]     regModel [32];

    // Table index held in each pipeline register, -1 when empty
    int              mIdx;
    int              wIdx;
    // Entry whose register the read ports point at
    string           readTag;

    int              checkCount;
    int              errorCount;
    bit              timedOut;

    backEnd #(
        .dmemWords (dmemWords)
    ) i_backEnd (
        .clk        (clk),
        .rstN       (rstN),
        .exIn       (exIn),
        .stallM     (stallM),
        .stallW     (stallW),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd1        (rd1),
        .rd2        (rd2),
        .aluResultM (aluResultM),
        .rdM        (rdM),
        .regWriteM  (regWriteM),
        .resultW    (resultW),
        .rdW        (rdW),
        .regWriteW  (regWriteW)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Memory and ALU fields random, store data from the table
    task automatic addEntry(input string name, input riscvPkg::resultSrcT src,
                            input riscvPkg::memWidthT width, input int memWr, input int regWr,
                            input int rd, input logic [31:0] offset, input logic [31:0] data,
                            input int stall);
        riscvPkg::exMemT ex;
        ex.aluResult = $urandom;
        ex.writeData = $urandom;
        // Loads and stores use the table offset as address
        if (memWr != 0 || src == riscvPkg::resultMemData) begin
            ex.aluResult = offset;
        end
        if (memWr != 0) begin
            ex.writeData = data;
        end
        ex.pcTarget = $urandom;
        ex.pcPlus4 = $urandom;
        ex.immExt = $urandom;
        ex.rd = 5'(rd);
        ex.resultSrc = src;
        ex.memWidth = width;
        ex.memWrite = (memWr != 0);
        ex.regWrite = (regWr != 0);
        names[numEntries] = name;
        exTab[numEntries] = ex;
        stallTab[numEntries] = (stall != 0);
        numEntries++;
    endtask

    // Little-endian read of the model, extension by width
    function automatic logic [31:0] loadValue(input logic [31:0] addr,
                                              input riscvPkg::memWidthT width);
        int         a;
        logic [7:0] b0;
        logic [7:0] b1;
        logic [7:0] b2;
        logic [7:0] b3;
        a = int'(addr);
        b0 = modelMem[a];
        b1 = modelMem[a + 1];
        b2 = modelMem[a + 2];
        b3 = modelMem[a + 3];
        case (width)
            riscvPkg::widthByte:  return {{24{b0[7]}}, b0};
            riscvPkg::widthByteU: return {24'h0, b0};
            riscvPkg::widthHalf:  return {{16{b1[7]}}, b1, b0};
            riscvPkg::widthHalfU: return {16'h0, b1, b0};
            default:              return {b3, b2, b1, b0};
        endcase
    endfunction

    function automatic logic [31:0] expectedResult(input riscvPkg::exMemT ex);
        case (ex.resultSrc)
            riscvPkg::resultAlu:      return ex.aluResult;
            riscvPkg::resultPcTarget: return ex.pcTarget;
            riscvPkg::resultPcPlus4:  return ex.pcPlus4;
            riscvPkg::resultImm:      return ex.immExt;
            default:                  return loadValue(ex.aluResult, ex.memWidth);
        endcase
    endfunction

    // Addresses in the table are aligned for their width
    task automatic storeModel(input riscvPkg::exMemT ex);
        int a;
        a = int'(ex.aluResult);
        modelMem[a] = ex.writeData[7:0];
        if (ex.memWidth inside {riscvPkg::widthHalf, riscvPkg::widthHalfU,
                                riscvPkg::widthWord}) begin
            modelMem[a + 1] = ex.writeData[15:8];
        end
        if (ex.memWidth == riscvPkg::widthWord) begin
            modelMem[a + 2] = ex.writeData[23:16];
            modelMem[a + 3] = ex.writeData[31:24];
        end
    endtask

    task automatic buildTable();
        // One result source per entry
        addEntry("alu_x5", riscvPkg::resultAlu, riscvPkg::widthWord, 0, 1, 5, 0, 0, 0);
        addEntry("pctarget_x6", riscvPkg::resultPcTarget, riscvPkg::widthWord, 0, 1, 6, 0, 0, 0);
        addEntry("pcplus4_x7", riscvPkg::resultPcPlus4, riscvPkg::widthWord, 0, 1, 7, 0, 0, 0);
        addEntry("imm_x8", riscvPkg::resultImm, riscvPkg::widthWord, 0, 1, 8, 0, 0, 0);
        // x0 writes
        addEntry("alu_x0", riscvPkg::resultAlu, riscvPkg::widthWord, 0, 1, 0, 0, 0, 0);
        addEntry("imm_x0", riscvPkg::resultImm, riscvPkg::widthWord, 0, 1, 0, 0, 0, 0);
        // Stores name live registers in rd, those must not change
        addEntry("sw_40", riscvPkg::resultAlu, riscvPkg::widthWord, 1, 0, 5, 'h40, 'h8badf00d, 0);
        addEntry("sw_44", riscvPkg::resultAlu, riscvPkg::widthWord, 1, 0, 6, 'h44, 'hfe807f01, 0);
        addEntry("sb_41", riscvPkg::resultAlu, riscvPkg::widthByte, 1, 0, 7, 'h41, 'h000000c3, 0);
        addEntry("sh_46", riscvPkg::resultAlu, riscvPkg::widthHalf, 1, 0, 8, 'h46, 'h0000a55a, 0);
        // Every width, negative and positive bytes and halves
        addEntry("lw_40", riscvPkg::resultMemData, riscvPkg::widthWord, 0, 1, 9, 'h40, 0, 0);
        addEntry("lb_41", riscvPkg::resultMemData, riscvPkg::widthByte, 0, 1, 10, 'h41, 0, 0);
        addEntry("lbu_41", riscvPkg::resultMemData, riscvPkg::widthByteU, 0, 1, 11, 'h41, 0, 0);
        addEntry("lb_40", riscvPkg::resultMemData, riscvPkg::widthByte, 0, 1, 12, 'h40, 0, 0);
        addEntry("lh_46", riscvPkg::resultMemData, riscvPkg::widthHalf, 0, 1, 13, 'h46, 0, 0);
        addEntry("lhu_46", riscvPkg::resultMemData, riscvPkg::widthHalfU, 0, 1, 14, 'h46, 0, 0);
        addEntry("lh_44", riscvPkg::resultMemData, riscvPkg::widthHalf, 0, 1, 15, 'h44, 0, 0);
        addEntry("lhu_42", riscvPkg::resultMemData, riscvPkg::widthHalfU, 0, 1, 16, 'h42, 0, 0);
        addEntry("lbu_47", riscvPkg::resultMemData, riscvPkg::widthByteU, 0, 1, 17, 'h47, 0, 0);
        addEntry("lw_44", riscvPkg::resultMemData, riscvPkg::widthWord, 0, 1, 18, 'h44, 0, 0);
        // Load straight behind a store to the same address
        addEntry("sw_80", riscvPkg::resultAlu, riscvPkg::widthWord, 1, 0, 9, 'h80, 'h13579bdf, 0);
        addEntry("lw_80", riscvPkg::resultMemData, riscvPkg::widthWord, 0, 1, 19, 'h80, 0, 0);
        addEntry("sb_82", riscvPkg::resultAlu, riscvPkg::widthByte, 1, 0, 10, 'h82, 'h000000fe, 0);
        addEntry("lbu_82", riscvPkg::resultMemData, riscvPkg::widthByteU, 0, 1, 20, 'h82, 0, 0);
        addEntry("lb_82", riscvPkg::resultMemData, riscvPkg::widthByte, 0, 1, 21, 'h82, 0, 0);
        addEntry("sh_84", riscvPkg::resultAlu, riscvPkg::widthHalf, 1, 0, 11, 'h84, 'h00008001, 0);
        addEntry("lh_84", riscvPkg::resultMemData, riscvPkg::widthHalf, 0, 1, 22, 'h84, 0, 0);
        // Held off by both stalls first
        addEntry("stall_x23", riscvPkg::resultAlu, riscvPkg::widthWord, 0, 1, 23, 0, 0, 1);
        addEntry("stall_lw", riscvPkg::resultMemData, riscvPkg::widthWord, 0, 1, 24, 'h80, 0, 1);
        addEntry("alu_x5_redo", riscvPkg::resultAlu, riscvPkg::widthWord, 0, 1, 5, 0, 0, 0);
        addEntry("lw_x0", riscvPkg::resultMemData, riscvPkg::widthWord, 0, 1, 0, 'h40, 0, 0);
    endtask

    // One clock cycle: check settled outputs, then drive the next inputs
    task automatic stepCycle(input int drvIdx, input bit stall);
        @(negedge clk);
        if (mIdx >= 0) begin
            checkValue({names[mIdx], " aluResultM"}, exTab[mIdx].aluResult, aluResultM);
            checkValue({names[mIdx], " rdM"}, 32'(exTab[mIdx].rd), 32'(rdM));
            checkValue({names[mIdx], " regWriteM"}, 32'(exTab[mIdx].regWrite), 32'(regWriteM));
        end
        if (wIdx >= 0) begin
            checkValue({names[wIdx], " resultW"}, expTab[wIdx], resultW);
            checkValue({names[wIdx], " rdW"}, 32'(exTab[wIdx].rd), 32'(rdW));
            checkValue({names[wIdx], " regWriteW"}, 32'(exTab[wIdx].regWrite), 32'(regWriteW));
        end
        // Read ports were set a cycle ago
        checkValue($sformatf("%s x%0d", readTag, rs1), regModel[rs1], rd1);
        checkValue($sformatf("%s x%0d", readTag, rs2), regModel[rs2], rd2);
        // Writeback entry lands in the register file at the next edge
        if (wIdx >= 0) begin
            if (exTab[wIdx].regWrite && exTab[wIdx].rd != 5'd0) begin
                regModel[exTab[wIdx].rd] = expTab[wIdx];
            end
            rs1 = exTab[wIdx].rd;
            readTag = names[wIdx];
        end else begin
            rs1 = 5'($urandom);
            readTag = "idle";
        end
        rs2 = 5'($urandom);
        if (drvIdx >= 0) begin
            exIn = exTab[drvIdx];
        end else begin
            exIn = '0;
        end
        stallM = stall;
        stallW = stall;
        // Pipeline occupancy after the coming edge
        if (!stall) begin
            if (drvIdx >= 0) begin
                expTab[drvIdx] = expectedResult(exTab[drvIdx]);
                if (exTab[drvIdx].memWrite) begin
                    storeModel(exTab[drvIdx]);
                end
            end
            wIdx = mIdx;
            mIdx = drvIdx;
        end
    endtask

    // Write enables low and all registers zero on both ports
    task automatic checkResetState();
        checkValue("reset regWriteM", 32'h0, 32'(regWriteM));
        checkValue("reset regWriteW", 32'h0, 32'(regWriteW));
        for (int a = 0; a < 32; a++) begin
            rs1 = 5'(a);
            rs2 = 5'(31 - a);
            @(negedge clk);
            checkValue($sformatf("reset x%0d", a), 32'h0, rd1);
            checkValue($sformatf("reset x%0d", 31 - a), 32'h0, rd2);
        end
    endtask

    task automatic runTable();
        for (int i = 0; i < numEntries; i++) begin
            if (stallTab[i]) begin
                for (int s = 0; s < stallCycles; s++) begin
                    stepCycle(i, 1'b1);
                end
            end
            stepCycle(i, 1'b0);
        end
    endtask

    // Bubbles until both pipeline registers are empty
    task automatic drainPipe();
        int cycles;
        cycles = 0;
        while ((mIdx >= 0 || wIdx >= 0) && cycles < waitLimit) begin
            stepCycle(-1, 1'b0);
            cycles++;
        end
        if (mIdx >= 0 || wIdx >= 0) begin
            $display("Timeout: pipeline did not drain");
            timedOut = 1'b1;
        end else begin
            // Last register write becomes readable here
            stepCycle(-1, 1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'h4f0901de));
        rstN = 1'b0;
        exIn = '0;
        stallM = 1'b0;
        stallW = 1'b0;
        rs1 = '0;
        rs2 = '0;
        numEntries = 0;
        mIdx = -1;
        wIdx = -1;
        readTag = "reset";
        checkCount = 0;
        errorCount = 0;
        timedOut = 1'b0;
        for (int r = 0; r < 32; r++) begin
            regModel[r] = '0;
        end
        for (int b = 0; b < memBytes; b++) begin
            modelMem[b] = '0;
        end
        buildTable();
        repeat (5) @(negedge clk);
        rstN = 1'b1;
        checkResetState();
        runTable();
        drainPipe();
        $display("Checks run: %0d, errors: %0d", checkCount, errorCount);
        if (timedOut || errorCount != 0) begin
            $display("Errors found");
        end else begin
            $display("No errors");
        end
        $finish;
    end

endmodule

//--- filelist.f
riscvPkg.sv
memoryStage.sv
writebackStage.sv
registerFile.sv
backEnd.sv
tbBackEnd.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tbBackEnd \
		-f filelist.f --Mdir obj_dir -o simBackEnd

run: compile
	./obj_dir/simBackEnd | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf obj_dir sim.log
